/* src.f */
+incdir+.
hwlp_instr_pkg.sv
hwlp_loop_pkg.sv
hwlp_setup_decoder.sv
riscv_hwloop_regs.sv
hwlp_controller.sv
hwlp_top.sv
hwlp_properties.sv
hwlp_tb.sv

/* Makefile */
# Verilator build and run of the hardware-loop testbench

.PHONY: all run clean

all: run

obj_dir/Vhwlp_tb: src.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module hwlp_tb -f src.f

run: obj_dir/Vhwlp_tb
	./obj_dir/Vhwlp_tb +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASS" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* hwlp_tb.sv */
// plays decode and fetch for hwlp_top against a loop register model
// setup words keep bits 10:7 at zero and loop offsets count halfwords
`include "hwlp_cfg.svh"

module hwlp_tb;

    localparam int timeout_cycles = 20;

    logic                        clk, rst_n;
    logic                        setup_req, setup_ack, setup_err;
    logic                        fetch_valid, jump;
    hwlp_instr_pkg::hwlp_instr_u setup_instr;
    logic [`HWLP_AW-1:0]         setup_pc, setup_rs1, fetch_pc, jump_target;

    // reference model of the loop registers
    logic [`HWLP_AW-1:0] m_start [`HWLP_NUM];
    logic [`HWLP_AW-1:0] m_end [`HWLP_NUM];
    logic [`HWLP_AW-1:0] m_cnt [`HWLP_NUM];
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int failed_tests = 0;
    int test_err0 = 0;

    hwlp_top dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .setup_req_i   (setup_req),
        .setup_instr_i (setup_instr),
        .setup_pc_i    (setup_pc),
        .setup_rs1_i   (setup_rs1),
        .setup_ack_o   (setup_ack),
        .setup_err_o   (setup_err),
        .fetch_pc_i    (fetch_pc),
        .fetch_valid_i (fetch_valid),
        .jump_o        (jump),
        .jump_target_o (jump_target)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic test_done(input string name);
        tests++;
        if (errors == test_err0) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, errors - test_err0);
        end
        test_err0 = errors;
    endtask

    // offset[31:20] rs1[19:15] funct[14:12] id[11] unused[10:7] opcode[6:0]
    function automatic logic [31:0] make_instr(input logic [6:0] op, input logic [2:0] fn,
                                               input logic id, input logic [11:0] off,
                                               input logic [4:0] rs);
        return {off, rs, fn, id, 4'b0000, op};
    endfunction

    task automatic model_write(input logic [31:0] w, input logic [31:0] pc,
                               input logic [31:0] rs1);
        logic [2:0]  fn;
        logic        id;
        logic [31:0] rel;

        fn  = w[14:12];
        id  = w[11];
        rel = pc + {{19{w[31]}}, w[31:20], 1'b0};
        case (fn)
            3'd0: m_start[id] = rel;
            3'd1: m_end[id] = rel;
            3'd2: m_cnt[id] = rs1;
            3'd3: m_cnt[id] = {20'd0, w[31:20]};
            3'd4, 3'd5: begin
                m_start[id] = pc + 32'd4;
                m_end[id]   = rel;
                m_cnt[id]   = (fn == 3'd5) ? {27'd0, w[19:15]} : rs1;
            end
            default: ;
        endcase
    endtask

    // inner loop 0 wins and a valid fetch decrements the winner
    task automatic model_fetch(input logic [31:0] pc, input logic valid,
                               output logic exp_jump, output logic [31:0] exp_tgt);
        int win;

        win      = -1;
        exp_jump = 1'b0;
        exp_tgt  = '0;
        for (int i = `HWLP_NUM - 1; i >= 0; i--) begin
            if (m_end[i] == pc && m_cnt[i] != 0) win = i;
        end
        if (win >= 0) begin
            exp_jump = m_cnt[win] > 1;
            exp_tgt  = m_start[win];
            if (valid) m_cnt[win] = m_cnt[win] - 1;
        end
    endtask

    task automatic fetch_cycle(input logic [31:0] pc, input logic valid, output logic jumped);
        logic        exp_jump;
        logic [31:0] exp_tgt;

        step();
        fetch_pc    = pc;
        fetch_valid = valid;
        @(negedge clk);
        model_fetch(pc, valid, exp_jump, exp_tgt);
        jumped = jump;
        check("jump_o", {31'd0, jump}, {31'd0, exp_jump});
        if (exp_jump) check("jump_target_o", jump_target, exp_tgt);
    endtask

    // with collide set, a valid fetch of col_pc lands on the write edge
    task automatic setup_xfer(input logic [31:0] w, input logic [31:0] pc,
                              input logic [31:0] rs1, input logic collide,
                              input logic [31:0] col_pc);
        logic        exp_err;
        logic        dj;
        logic [31:0] dt;
        int          n;

        exp_err = (w[6:0] != `HWLP_OPCODE) || (w[14:13] == 2'b11);
        step();
        setup_req   = 1'b1;
        setup_instr = w;
        setup_pc    = pc;
        setup_rs1   = rs1;
        fetch_valid = 1'b0;
        n = 0;
        while (!setup_ack && n < timeout_cycles) begin
            step();
            fetch_pc    = col_pc;
            fetch_valid = collide && (n == 0);
            n++;
        end
        if (!setup_ack) begin
            $display("setup transfer got no ack within %0d cycles", timeout_cycles);
            errors++;
        end
        check("setup_err_o", {31'd0, setup_err}, {31'd0, exp_err});
        // decrement first so that the colliding write overrides it
        if (collide) model_fetch(col_pc, 1'b1, dj, dt);
        if (!exp_err) model_write(w, pc, rs1);
        step();
        setup_req = 1'b0;
        n = 0;
        while (setup_ack && n < timeout_cycles) begin
            step();
            n++;
        end
        if (setup_ack) begin
            $display("setup ack stayed high after req fell");
            errors++;
        end
        check("setup_err_o", {31'd0, setup_err}, 32'd0);
    endtask

    initial begin
        logic [31:0] pc, w;
        logic        j;
        int          n, jumps;

        void'($urandom(32'he298));
        rst_n       = 1'b0;
        setup_req   = 1'b0;
        setup_instr = '0;
        setup_pc    = '0;
        setup_rs1   = '0;
        fetch_pc    = '0;
        fetch_valid = 1'b0;
        for (int i = 0; i < `HWLP_NUM; i++) begin
            m_start[i] = '0;
            m_end[i]   = '0;
            m_cnt[i]   = '0;
        end

        // reset holds over four rising edges
        repeat (3) begin
            step();
            fetch_pc = $urandom;
            @(negedge clk);
            check("jump_o", {31'd0, jump}, 32'd0);
            check("setup_ack_o", {31'd0, setup_ack}, 32'd0);
            check("setup_err_o", {31'd0, setup_err}, 32'd0);
        end
        step();
        rst_n = 1'b1;
        repeat (4) fetch_cycle($urandom, 1'b1, j);
        test_done("reset");

        repeat (12) begin
            w = make_instr(`HWLP_OPCODE, 3'($urandom_range(5, 0)), 1'($urandom),
                           12'($urandom), 5'($urandom));
            setup_xfer(w, $urandom & 32'hffff_fffe, $urandom_range(9, 0), 1'b0, '0);
            fetch_cycle(m_end[w[11]], 1'b0, j);
        end
        test_done("setup forms");

        setup_xfer(make_instr(`HWLP_OPCODE, 3'd5, 1'b0, 12'h040, 5'd5), 32'h1000, 0, 1'b0, 0);
        setup_xfer(make_instr(`HWLP_OPCODE, 3'd5, 1'b1, 12'h080, 5'd5), 32'h1000, 0, 1'b0, 0);
        repeat (6) begin
            if ($urandom_range(1, 0) == 1) begin
                w = make_instr(`HWLP_OPCODE ^ 7'($urandom_range(127, 1)),
                               3'($urandom_range(5, 0)), 1'($urandom), 12'($urandom), 5'd3);
            end else begin
                w = make_instr(`HWLP_OPCODE, 3'($urandom_range(7, 6)), 1'($urandom),
                               12'($urandom), 5'd3);
            end
            setup_xfer(w, $urandom, $urandom, 1'b0, 0);
        end
        // run both loops out so that a stray counter write shows up
        repeat (6) fetch_cycle(m_end[0], 1'b1, j);
        repeat (6) fetch_cycle(m_end[1], 1'b1, j);
        test_done("illegal words");

        // loop 1 parked with a zero counter
        setup_xfer(make_instr(`HWLP_OPCODE, 3'd2, 1'b1, 12'd0, 5'd0), 0, 0, 1'b0, 0);
        n  = $urandom_range(9, 2);
        pc = 32'h2000 + ($urandom_range(255, 0) << 2);
        setup_xfer(make_instr(`HWLP_OPCODE, 3'd5, 1'b0, 12'h020, 5'(n)), pc, 0, 1'b0, 0);
        jumps = 0;
        for (int k = 0; k < n + 2; k++) begin
            fetch_cycle(m_end[0], 1'b1, j);
            if (j) jumps++;
        end
        check("jump_o count", jumps, n - 1);
        test_done("single loop");

        // both loops end at 32'h3020
        setup_xfer(make_instr(`HWLP_OPCODE, 3'd5, 1'b0, 12'h010, 5'($urandom_range(4, 2))),
                   32'h3000, 0, 1'b0, 0);
        setup_xfer(make_instr(`HWLP_OPCODE, 3'd4, 1'b1, 12'h020, 5'd0), 32'h2fe0,
                   $urandom_range(4, 2), 1'b0, 0);
        for (int k = 0; k < 24; k++) fetch_cycle(32'h3020, (k % 3) != 2, j);
        test_done("nesting priority");

        setup_xfer(make_instr(`HWLP_OPCODE, 3'd5, 1'b0, 12'h030, 5'd6), 32'h4000, 0, 1'b0, 0);
        setup_xfer(make_instr(`HWLP_OPCODE, 3'd2, 1'b0, 12'd0, 5'd1), 0, 32'd3, 1'b1, 32'h4060);
        jumps = 0;
        repeat (4) begin
            fetch_cycle(32'h4060, 1'b1, j);
            if (j) jumps++;
        end
        check("jump_o count", jumps, 2);
        test_done("write precedence");

        $display("tests %0d, failed %0d, checks %0d, errors %0d, property failures %0d",
                 tests, failed_tests, checks, errors, dut_i.u_props.fail_count);
        if (errors == 0 && failed_tests == 0 && dut_i.u_props.fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* hwlp_properties.sv */
// concurrent checks on the setup handshake and the jump output
// bound into hwlp_top, sampled on the rising clock
module hwlp_properties (
    input logic clk,
    input logic rst_n,
    input logic req_i,
    input logic ack_i,
    input logic jump_i
);

    // number of failed assertions, read by the testbench at the end
    int unsigned fail_count = 0;

    // ack only answers a pending request
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack_i) |-> req_i)
        else begin
            fail_count++;
            $error("setup ack rose without a request");
        end

    // held request keeps ack up
    ack_held: assert property (@(posedge clk) disable iff (!rst_n)
        ack_i && req_i |=> ack_i)
        else begin
            fail_count++;
            $error("setup ack dropped while request was held");
        end

    jump_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !jump_i)
        else begin
            fail_count++;
            $error("jump raised during reset");
        end

endmodule

bind hwlp_top hwlp_properties u_props (
    .clk    (clk),
    .rst_n  (rst_n),
    .req_i  (setup_req_i),
    .ack_i  (setup_ack_o),
    .jump_i (jump_o)
);

/* hwlp_top.sv */
// hardware-loop unit; jump outputs are combinational from fetch_pc_i,
// fetch_valid_i only gates the counter decrement
`include "hwlp_cfg.svh"

module hwlp_top (
    input  logic                        clk,
    input  logic                        rst_n,

    // setup port from decode
    input  logic                        setup_req_i,
    input  hwlp_instr_pkg::hwlp_instr_u setup_instr_i,
    input  logic [`HWLP_AW-1:0]         setup_pc_i,
    input  logic [`HWLP_AW-1:0]         setup_rs1_i,
    output logic                        setup_ack_o,
    output logic                        setup_err_o,

    // fetch port
    input  logic [`HWLP_AW-1:0]         fetch_pc_i,
    input  logic                        fetch_valid_i,
    output logic                        jump_o,
    output logic [`HWLP_AW-1:0]         jump_target_o
);

    hwlp_loop_pkg::hwlp_wr_t    wr;
    hwlp_loop_pkg::hwlp_regs_t  regs;
    logic [`HWLP_NUM-1:0]       cnt_dec;

    hwlp_setup_decoder u_decoder (
        .clk           (clk),
        .rst_n         (rst_n),
        .setup_req_i   (setup_req_i),
        .setup_instr_i (setup_instr_i),
        .setup_pc_i    (setup_pc_i),
        .setup_rs1_i   (setup_rs1_i),
        .setup_ack_o   (setup_ack_o),
        .setup_err_o   (setup_err_o),
        .wr_o          (wr)
    );

    riscv_hwloop_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_i      (wr),
        .valid_i   (fetch_valid_i),
        .cnt_dec_i (cnt_dec),
        .regs_o    (regs)
    );

    hwlp_controller u_ctrl (
        .regs_i        (regs),
        .fetch_pc_i    (fetch_pc_i),
        .cnt_dec_o     (cnt_dec),
        .jump_o        (jump_o),
        .jump_target_o (jump_target_o)
    );

endmodule

/* hwlp_controller.sv */
// combinational loop-end match; no nesting legality checks, loop 0 is
// taken as the inner loop and wins over loop 1
`include "hwlp_cfg.svh"

module hwlp_controller (
    input  hwlp_loop_pkg::hwlp_regs_t   regs_i,
    input  logic [`HWLP_AW-1:0]         fetch_pc_i,
    output logic [`HWLP_NUM-1:0]        cnt_dec_o,
    output logic                        jump_o,
    output logic [`HWLP_AW-1:0]         jump_target_o
);

    logic [`HWLP_NUM-1:0] hit;

    // a loop with a zero counter is finished and never matches
    always_comb begin
        for (int i = 0; i < `HWLP_NUM; i++) begin
            hit[i] = (regs_i[i].end_addr == fetch_pc_i) && (regs_i[i].cnt != '0);
        end
    end

    // lowest index wins
    always_comb begin
        logic found;

        found         = 1'b0;
        cnt_dec_o     = '0;
        jump_o        = 1'b0;
        jump_target_o = '0;
        for (int i = 0; i < `HWLP_NUM; i++) begin
            if (hit[i] && !found) begin
                found        = 1'b1;
                cnt_dec_o[i] = 1'b1;
                // last iteration falls through
                if (regs_i[i].cnt > `HWLP_AW'(1)) begin
                    jump_o        = 1'b1;
                    jump_target_o = regs_i[i].start;
                end
            end
        end
    end

endmodule

/* riscv_hwloop_regs.sv */
// start, end and counter of each loop; a counter write on the same edge as
// a decrement wins over the decrement
`include "hwlp_cfg.svh"

module riscv_hwloop_regs (
    input  logic                        clk,
    input  logic                        rst_n,

    // write command from the setup decoder
    input  hwlp_loop_pkg::hwlp_wr_t     wr_i,

    // fetch pc valid, gates the decrement
    input  logic                        valid_i,

    // one-hot decrement from the controller
    input  logic [`HWLP_NUM-1:0]        cnt_dec_i,

    // all loop registers to the controller
    output hwlp_loop_pkg::hwlp_regs_t   regs_o
);

    hwlp_loop_pkg::hwlp_regs_t regs_q;

    assign regs_o = regs_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            regs_q <= '0;
        end else begin
            for (int i = 0; i < `HWLP_NUM; i++) begin
                // start address
                if (wr_i.we[0] && (wr_i.id == 1'(i))) begin
                    regs_q[i].start <= wr_i.start;
                end

                // end address
                if (wr_i.we[1] && (wr_i.id == 1'(i))) begin
                    regs_q[i].end_addr <= wr_i.end_addr;
                end

                // counter, setup write first
                if (wr_i.we[2] && (wr_i.id == 1'(i))) begin
                    regs_q[i].cnt <= wr_i.cnt;
                end else if (cnt_dec_i[i] && valid_i) begin
                    regs_q[i].cnt <= regs_q[i].cnt - `HWLP_AW'(1);
                end
            end
        end
    end

endmodule

/* hwlp_setup_decoder.sv */
// four-phase setup port; instruction, pc and rs1 must be held stable from req
// rising until ack falls, illegal words are acked with err and write nothing
`include "hwlp_cfg.svh"

module hwlp_setup_decoder (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        setup_req_i,
    input  hwlp_instr_pkg::hwlp_instr_u setup_instr_i,
    input  logic [`HWLP_AW-1:0]         setup_pc_i,
    input  logic [`HWLP_AW-1:0]         setup_rs1_i,
    output logic                        setup_ack_o,
    output logic                        setup_err_o,
    output hwlp_loop_pkg::hwlp_wr_t     wr_o
);

    typedef enum logic [1:0] {st_idle, st_ack, st_wait} state_e;

    state_e                         state_q, state_d;
    logic                           err_q;
    logic                           legal;
    logic [2:0]                     we_sel;
    logic [`HWLP_AW-1:0]            off2;
    hwlp_instr_pkg::hwlp_funct_e    funct;

    assign funct = setup_instr_i.i.funct;
    // pc-relative offsets count halfwords
    assign off2  = {{(`HWLP_AW-`HWLP_IMM_W-1){setup_instr_i.i.offset[`HWLP_IMM_W-1]}},
                    setup_instr_i.i.offset, 1'b0};

    always_comb begin
        we_sel = 3'b000;
        case (funct)
            hwlp_instr_pkg::fn_starti: we_sel = 3'b001;
            hwlp_instr_pkg::fn_endi:   we_sel = 3'b010;
            hwlp_instr_pkg::fn_count,
            hwlp_instr_pkg::fn_counti: we_sel = 3'b100;
            hwlp_instr_pkg::fn_setup,
            hwlp_instr_pkg::fn_setupi: we_sel = 3'b111;
            default:                   we_sel = 3'b000;
        endcase
        legal = (setup_instr_i.i.opcode == `HWLP_OPCODE) && (we_sel != 3'b000);
    end

    // payload
    always_comb begin
        wr_o.we       = (state_q == st_ack && legal) ? we_sel : 3'b000;
        wr_o.id       = setup_instr_i.i.loop_id;
        wr_o.end_addr = setup_pc_i + off2;
        if (funct == hwlp_instr_pkg::fn_setup || funct == hwlp_instr_pkg::fn_setupi) begin
            wr_o.start = setup_pc_i + `HWLP_AW'(4);
        end else begin
            wr_o.start = setup_pc_i + off2;
        end
        case (funct)
            hwlp_instr_pkg::fn_counti:
                wr_o.cnt = {{(`HWLP_AW-`HWLP_IMM_W){1'b0}}, setup_instr_i.i.offset};
            hwlp_instr_pkg::fn_setupi:
                wr_o.cnt = {{(`HWLP_AW-5){1'b0}}, setup_instr_i.s.count_imm};
            default:
                wr_o.cnt = setup_rs1_i;
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: if (setup_req_i) state_d = st_ack;
            st_ack:  state_d = st_wait;
            st_wait: if (!setup_req_i) state_d = st_idle;
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            // err is captured with the write and held for the ack phase
            if (state_q == st_ack) begin
                err_q <= !legal;
            end else if (state_d == st_idle) begin
                err_q <= 1'b0;
            end
        end
    end

    assign setup_ack_o = (state_q == st_wait);
    assign setup_err_o = err_q;

endmodule

/* hwlp_loop_pkg.sv */
// loop register write and readout types; loop id is one bit wide
`include "hwlp_cfg.svh"

package hwlp_loop_pkg;

    // we[0] start, we[1] end, we[2] counter
    typedef struct packed {
        logic [2:0]             we;
        logic                   id;
        logic [`HWLP_AW-1:0]    start;
        logic [`HWLP_AW-1:0]    end_addr;
        logic [`HWLP_AW-1:0]    cnt;
    } hwlp_wr_t;

    typedef struct packed {
        logic [`HWLP_AW-1:0]    start;
        logic [`HWLP_AW-1:0]    end_addr;
        logic [`HWLP_AW-1:0]    cnt;
    } hwlp_loop_t;

    // index 0 is the inner loop
    typedef hwlp_loop_t [`HWLP_NUM-1:0] hwlp_regs_t;

endpackage

/* hwlp_instr_pkg.sv */
// encoding of the lp.* setup instructions; bits 10:7 are ignored by the decoder
package hwlp_instr_pkg;

    // funct3 codes, 3'b110 and 3'b111 are illegal
    typedef enum logic [2:0] {
        fn_starti = 3'b000,
        fn_endi   = 3'b001,
        fn_count  = 3'b010,
        fn_counti = 3'b011,
        fn_setup  = 3'b100,
        fn_setupi = 3'b101
    } hwlp_funct_e;

    // register form, rs1 bits name a source register
    typedef struct packed {
        logic signed [11:0] offset;
        logic [4:0]         rs1;
        hwlp_funct_e        funct;
        logic               loop_id;
        logic [3:0]         unused;
        logic [6:0]         opcode;
    } hwlp_iform_t;

    // setupi form, rs1 bits carry the iteration count
    typedef struct packed {
        logic [11:0]        end_off;
        logic [4:0]         count_imm;
        hwlp_funct_e        funct;
        logic               loop_id;
        logic [3:0]         unused;
        logic [6:0]         opcode;
    } hwlp_sform_t;

    typedef union packed {
        hwlp_iform_t i;
        hwlp_sform_t s;
    } hwlp_instr_u;

endpackage

/* hwlp_cfg.svh */
// sizing of the hardware-loop unit; HWLP_NUM must stay 2 since the
// instruction word carries a single loop id bit
`ifndef HWLP_CFG_SVH
`define HWLP_CFG_SVH

// number of hardware loops, one regid bit
`define HWLP_NUM 2

// width of loop addresses and counters
`define HWLP_AW 32

// custom-3 major opcode of the lp.* instructions
`define HWLP_OPCODE 7'b1111011

// bits 31:20 hold the 12-bit immediate in both instruction forms
`define HWLP_IMM_W 12

`endif
